/* src/memtest_pkg.sv */
// Memory tester shared definitions
package memtest_pkg;

  // Data path widths
  localparam int lane_width_c  = 64;
  localparam int beat_width_c  = 2 * lane_width_c;  // One controller beat, two lanes
  localparam int addr_width_c  = 31;
  localparam int burst_width_c = 29;                // Burst index, address bits 30:2

  // 16-bit status words needed for one 256-bit burst
  localparam int halfwords_per_burst_c = 16;

  // Writable control words
  localparam int ctrl_reg_c    = 0;  // Bit 0 start, bit 1 reset
  localparam int size_lo_reg_c = 1;
  localparam int size_hi_reg_c = 2;
  localparam int rdblk_reg_c   = 3;

  // Status map, capture sections follow fault_base_c
  localparam int status_reg_c = 4;  // Bit 0 done, bit 1 fault, bit 2 afull event
  localparam int afull_reg_c  = 5;  // Two words
  localparam int fault_base_c = 7;

  // Sequencer states
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_wr_beat0   = 3'd1,
    st_wr_beat1   = 3'd2,
    st_wr_backoff = 3'd3,
    st_turn       = 3'd4,
    st_read       = 3'd5,
    st_rd_backoff = 3'd6,
    st_wait_data  = 3'd7
  } test_state_t;

endpackage

/* src/memtest_regs.sv */
`timescale 1ns/1ps
// Control and status register slave
module memtest_regs import memtest_pkg::*; #(
  parameter int FAULT_DEPTH = 4,
  parameter int RDBLK_DEPTH = 4
) (
  input  logic                                   clk,
  input  logic                                   module_rst,
  input  logic                                   phy_rdy_i,
  input  logic                                   bus_cyc_i,
  input  logic                                   bus_stb_i,
  input  logic                                   bus_we_i,
  input  logic [15:0]                            bus_adr_i,
  input  logic [15:0]                            bus_dat_i,
  output logic [15:0]                            bus_dat_o,
  output logic                                   bus_ack_o,
  output logic                                   start_o,
  output logic                                   test_rst_o,
  output logic [burst_width_c-1:0]               burst_count_o,
  output logic [addr_width_c-1:0]                rdblk_addr_o,
  input  logic [2:0]                             status_i,
  input  logic [burst_width_c-1:0]               afull_addr_i,
  input  logic [FAULT_DEPTH*2*beat_width_c-1:0]  fault_data_i,
  input  logic [FAULT_DEPTH*addr_width_c-1:0]    fault_addr_i,
  input  logic [RDBLK_DEPTH*2*beat_width_c-1:0]  rdblk_data_i,
  input  logic [RDBLK_DEPTH*addr_width_c-1:0]    rdblk_addr_cap_i
);

  // Section bases of the status map
  localparam int fault_addr_base_c = fault_base_c + FAULT_DEPTH * halfwords_per_burst_c;
  localparam int rdblk_data_base_c = fault_addr_base_c + FAULT_DEPTH * 2;
  localparam int rdblk_addr_base_c = rdblk_data_base_c + RDBLK_DEPTH * halfwords_per_burst_c;
  localparam int map_end_c         = rdblk_addr_base_c + RDBLK_DEPTH * 2;

  logic        ack_q;
  logic        access;
  logic [1:0]  ctrl_q;
  logic [15:0] size_lo_q;
  logic [12:0] size_hi_q;
  logic [15:0] rdblk_q;
  logic        start_d_q;
  logic        rst_d_q;
  logic [15:0] rd_word;
  logic [FAULT_DEPTH*32-1:0] fault_addr_w;  // Addresses padded to two words
  logic [RDBLK_DEPTH*32-1:0] rdblk_addr_w;

  assign access    = bus_cyc_i & bus_stb_i & ~ack_q;  // New access, not yet acked
  assign bus_ack_o = ack_q;

  always_ff @(posedge clk) begin
    if (module_rst) begin
      ack_q     <= 1'b0;
      ctrl_q    <= 2'b00;
      size_lo_q <= '0;
      size_hi_q <= '0;
      rdblk_q   <= '0;
      rst_d_q   <= 1'b0;
    end else begin
      ack_q   <= access;
      rst_d_q <= ctrl_q[1];
      if (access && bus_we_i) begin
        case (bus_adr_i)
          ctrl_reg_c:    ctrl_q    <= bus_dat_i[1:0];
          size_lo_reg_c: size_lo_q <= bus_dat_i;
          size_hi_reg_c: size_hi_q <= bus_dat_i[12:0];
          rdblk_reg_c:   rdblk_q   <= bus_dat_i;
          default:       ;  // Status map is read only
        endcase
      end
    end
  end

  // Start edge detect, rearmed by any test reset
  always_ff @(posedge clk) begin
    if (test_rst_o) begin
      start_d_q <= 1'b1;
    end else begin
      start_d_q <= ctrl_q[0];
    end
  end

  assign start_o    = ctrl_q[0] & ~start_d_q;
  assign test_rst_o = (ctrl_q[1] & ~rst_d_q) | module_rst | ~phy_rdy_i;

  assign burst_count_o = {size_hi_q, size_lo_q};
  assign rdblk_addr_o  = {{(addr_width_c - 16){1'b0}}, rdblk_q};

  for (genvar i = 0; i < FAULT_DEPTH; i++) begin : g_fault_addr
    assign fault_addr_w[i*32 +: 32] = {1'b0, fault_addr_i[i*addr_width_c +: addr_width_c]};
  end

  for (genvar i = 0; i < RDBLK_DEPTH; i++) begin : g_rdblk_addr
    assign rdblk_addr_w[i*32 +: 32] = {1'b0, rdblk_addr_cap_i[i*addr_width_c +: addr_width_c]};
  end

  // Status word select
  always_comb begin
    rd_word = 16'h0000;
    case (bus_adr_i)
      ctrl_reg_c:      rd_word = {14'h0000, ctrl_q};
      size_lo_reg_c:   rd_word = size_lo_q;
      size_hi_reg_c:   rd_word = {3'b000, size_hi_q};
      rdblk_reg_c:     rd_word = rdblk_q;
      status_reg_c:    rd_word = {13'h0000, status_i};
      afull_reg_c:     rd_word = afull_addr_i[15:0];
      afull_reg_c + 1: rd_word = {3'b000, afull_addr_i[burst_width_c-1:16]};
      default: begin
        if (bus_adr_i >= fault_base_c && bus_adr_i < fault_addr_base_c) begin
          rd_word = fault_data_i[(bus_adr_i - fault_base_c) * 16 +: 16];
        end else if (bus_adr_i >= fault_addr_base_c && bus_adr_i < rdblk_data_base_c) begin
          rd_word = fault_addr_w[(bus_adr_i - fault_addr_base_c) * 16 +: 16];
        end else if (bus_adr_i >= rdblk_data_base_c && bus_adr_i < rdblk_addr_base_c) begin
          rd_word = rdblk_data_i[(bus_adr_i - rdblk_data_base_c) * 16 +: 16];
        end else if (bus_adr_i >= rdblk_addr_base_c && bus_adr_i < map_end_c) begin
          rd_word = rdblk_addr_w[(bus_adr_i - rdblk_addr_base_c) * 16 +: 16];
        end
      end
    endcase
  end

  // Read data lines up with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      bus_dat_o <= rd_word;
    end
  end

endmodule

/* src/memtest_sequencer.sv */
`timescale 1ns/1ps
// Write and read-back sequencer
module memtest_sequencer import memtest_pkg::*; (
  input  logic                     clk,
  input  logic                     test_rst_i,
  input  logic                     start_i,
  input  logic [burst_width_c-1:0] burst_count_i,
  input  logic                     mem_af_afull_i,
  input  logic                     mem_df_afull_i,
  input  logic                     read_end_i,
  output logic                     mem_rd_wr_n_o,
  output logic [addr_width_c-1:0]  mem_addr_o,
  output logic [beat_width_c-1:0]  mem_data_o,
  output logic                     mem_af_we_o,
  output logic                     mem_df_we_o,
  output logic                     phase_write_o,
  output logic                     phase_turn_o,
  output logic                     done_o,
  output logic                     afull_event_o,
  output logic [burst_width_c-1:0] afull_addr_o
);

  test_state_t state_q;

  logic [burst_width_c-1:0] burst_q;
  logic [lane_width_c-1:0]  lane0_q;
  logic [lane_width_c-1:0]  lane1_q;
  logic                     afull;
  logic                     last_burst;
  logic                     done_q;
  logic                     afull_event_q;
  logic [burst_width_c-1:0] afull_addr_q;

  assign afull      = mem_af_afull_i | mem_df_afull_i;
  assign last_burst = (burst_q == burst_count_i - 1'b1);

  always_ff @(posedge clk) begin
    if (test_rst_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (start_i) state_q <= st_wr_beat0;
        end
        st_wr_beat0: state_q <= st_wr_beat1;
        st_wr_beat1: begin
          if (last_burst) begin
            state_q <= st_turn;
          end else if (afull) begin  // Flags checked after the whole burst
            state_q <= st_wr_backoff;
          end else begin
            state_q <= st_wr_beat0;
          end
        end
        st_wr_backoff: begin
          if (!afull) state_q <= st_wr_beat0;
        end
        st_turn: state_q <= st_read;
        st_read: begin
          if (last_burst) begin
            state_q <= st_wait_data;
          end else if (afull) begin
            state_q <= st_rd_backoff;
          end
        end
        st_rd_backoff: begin
          if (!afull) state_q <= st_read;
        end
        st_wait_data: begin
          if (read_end_i) state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Burst index and write pattern, lane k of burst n is 4n+k
  always_ff @(posedge clk) begin
    if (state_q == st_idle) begin
      burst_q <= '0;
      lane0_q <= lane_width_c'(0);
      lane1_q <= lane_width_c'(1);
    end else begin
      if (state_q == st_turn) begin
        burst_q <= '0;
      end else if (state_q == st_wr_beat1 || state_q == st_read) begin
        burst_q <= burst_q + 1'b1;
      end
      if (state_q == st_wr_beat0 || state_q == st_wr_beat1) begin
        lane0_q <= lane0_q + lane_width_c'(2);
        lane1_q <= lane1_q + lane_width_c'(2);
      end
    end
  end

  assign mem_rd_wr_n_o = (state_q != st_wr_beat0);
  assign mem_af_we_o   = (state_q == st_wr_beat0) || (state_q == st_read);
  assign mem_df_we_o   = (state_q == st_wr_beat0) || (state_q == st_wr_beat1);
  assign mem_addr_o    = {burst_q, 2'b00};
  assign mem_data_o    = {lane1_q, lane0_q};

  assign phase_write_o = (state_q == st_wr_beat0);
  assign phase_turn_o  = (state_q == st_turn);

  always_ff @(posedge clk) begin
    if (test_rst_i) begin
      done_q        <= 1'b0;
      afull_event_q <= 1'b0;
      afull_addr_q  <= '0;
    end else begin
      if (start_i) begin
        done_q <= 1'b0;
      end else if (state_q == st_wait_data && read_end_i) begin
        done_q <= 1'b1;
      end
      if (start_i) begin
        afull_event_q <= 1'b0;
      end else if (afull && !afull_event_q && state_q != st_idle) begin
        afull_event_q <= 1'b1;  // First one only
        afull_addr_q  <= burst_q;
      end
    end
  end

  assign done_o        = done_q;
  assign afull_event_o = afull_event_q;
  assign afull_addr_o  = afull_addr_q;

endmodule

/* src/memtest_checker.sv */
`timescale 1ns/1ps
// Read data checker with fault and read-block capture
module memtest_checker import memtest_pkg::*; #(
  parameter int FAULT_DEPTH = 4,
  parameter int RDBLK_DEPTH = 4
) (
  input  logic                                   clk,
  input  logic                                   test_rst_i,
  input  logic                                   phase_write_i,
  input  logic                                   phase_turn_i,
  input  logic [addr_width_c-1:0]                rdblk_addr_i,
  input  logic [beat_width_c-1:0]                mem_data_i,
  input  logic                                   mem_dvalid_i,
  output logic                                   read_end_o,
  output logic                                   fault_o,
  output logic [FAULT_DEPTH*2*beat_width_c-1:0]  fault_data_o,
  output logic [FAULT_DEPTH*addr_width_c-1:0]    fault_addr_o,
  output logic [RDBLK_DEPTH*2*beat_width_c-1:0]  rdblk_data_o,
  output logic [RDBLK_DEPTH*addr_width_c-1:0]    rdblk_addr_cap_o
);

  localparam int burst_bits_c = 2 * beat_width_c;

  logic                     beat_sel_q;  // High when the next beat is the upper half
  logic [2:0]               bvld_q;      // Whole burst valid per stage
  logic [3:0]               dvd_q;       // Raw valid delay
  logic [burst_bits_c-1:0]  pack_q;
  logic [burst_bits_c-1:0]  data_q;
  logic [burst_bits_c-1:0]  cmp_data_q;
  logic [addr_width_c-1:0]  cmp_addr_q;
  logic                     cmp_bad_q;
  logic [burst_width_c-1:0] exp_burst_q;
  logic [addr_width_c-1:0]  exp_addr;
  logic [burst_bits_c-1:0]  exp_data;
  logic                     fault_q;
  logic                     rdblk_hit;
  logic [$clog2(FAULT_DEPTH):0] fault_cnt_q;
  logic [$clog2(RDBLK_DEPTH):0] rdblk_cnt_q;
  logic [FAULT_DEPTH-1:0][burst_bits_c-1:0] fault_data_q;
  logic [FAULT_DEPTH-1:0][addr_width_c-1:0] fault_addr_q;
  logic [RDBLK_DEPTH-1:0][burst_bits_c-1:0] rdblk_data_q;
  logic [RDBLK_DEPTH-1:0][addr_width_c-1:0] rdblk_addr_q;

  // Expected burst from the burst index
  assign exp_addr = {exp_burst_q, 2'b00};
  for (genvar k = 0; k < 4; k++) begin : g_exp_lane
    assign exp_data[k*lane_width_c +: lane_width_c] =
      lane_width_c'(exp_addr) + lane_width_c'(k);
  end

  always_ff @(posedge clk) begin
    if (test_rst_i) begin
      beat_sel_q <= 1'b0;
      bvld_q     <= '0;
      dvd_q      <= '0;
      cmp_bad_q  <= 1'b0;
    end else begin
      beat_sel_q <= mem_dvalid_i & ~beat_sel_q;
      bvld_q     <= {bvld_q[1:0], mem_dvalid_i & beat_sel_q};
      dvd_q      <= {dvd_q[2:0], mem_dvalid_i};
      cmp_bad_q  <= bvld_q[1] && (data_q != exp_data);
    end
  end

  // Falls one cycle after the last burst is captured
  assign read_end_o = dvd_q[3] & ~dvd_q[2];

  // Beat packing and compare pipeline
  always_ff @(posedge clk) begin
    if (mem_dvalid_i) begin
      pack_q[beat_sel_q*beat_width_c +: beat_width_c] <= mem_data_i;
    end
    if (bvld_q[0]) begin
      data_q <= pack_q;
    end
    if (bvld_q[1]) begin
      cmp_data_q <= data_q;
      cmp_addr_q <= exp_addr;
    end
    if (phase_turn_i) begin
      exp_burst_q <= '0;
    end else if (bvld_q[1]) begin
      exp_burst_q <= exp_burst_q + 1'b1;
    end
  end

  assign rdblk_hit = (rdblk_cnt_q != '0) || (cmp_addr_q == rdblk_addr_i);

  always_ff @(posedge clk) begin
    if (test_rst_i || phase_write_i) begin
      fault_q     <= 1'b0;
      fault_cnt_q <= '0;
      rdblk_cnt_q <= '0;
    end else if (bvld_q[2]) begin
      if (cmp_bad_q) begin
        fault_q <= 1'b1;
        if (fault_cnt_q != FAULT_DEPTH) fault_cnt_q <= fault_cnt_q + 1'b1;
      end
      if (rdblk_cnt_q != RDBLK_DEPTH && rdblk_hit) begin
        rdblk_cnt_q <= rdblk_cnt_q + 1'b1;
      end
    end
  end

  // Capture slots, emptied at the start of each run
  always_ff @(posedge clk) begin
    if (phase_write_i) begin
      fault_data_q <= '0;
      fault_addr_q <= '0;
      rdblk_data_q <= '0;
      rdblk_addr_q <= '0;
    end else if (bvld_q[2]) begin
      if (cmp_bad_q && fault_cnt_q != FAULT_DEPTH) begin
        fault_data_q[fault_cnt_q] <= cmp_data_q;
        fault_addr_q[fault_cnt_q] <= cmp_addr_q;
      end
      if (rdblk_cnt_q != RDBLK_DEPTH && rdblk_hit) begin
        rdblk_data_q[rdblk_cnt_q] <= cmp_data_q;
        rdblk_addr_q[rdblk_cnt_q] <= cmp_addr_q;
      end
    end
  end

  assign fault_o          = fault_q;
  assign fault_data_o     = fault_data_q;
  assign fault_addr_o     = fault_addr_q;
  assign rdblk_data_o     = rdblk_data_q;
  assign rdblk_addr_cap_o = rdblk_addr_q;

endmodule

/* src/memtest_top.sv */
`timescale 1ns/1ps
// DDR memory tester top level
module memtest_top import memtest_pkg::*; #(
  parameter int FAULT_DEPTH = 4,
  parameter int RDBLK_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    module_rst,
  input  logic                    phy_rdy_i,
  input  logic                    bus_cyc_i,
  input  logic                    bus_stb_i,
  input  logic                    bus_we_i,
  input  logic [15:0]             bus_adr_i,
  input  logic [15:0]             bus_dat_i,
  output logic [15:0]             bus_dat_o,
  output logic                    bus_ack_o,
  output logic                    mem_rd_wr_n_o,
  output logic [addr_width_c-1:0] mem_addr_o,
  output logic [beat_width_c-1:0] mem_data_o,
  output logic                    mem_af_we_o,
  output logic                    mem_df_we_o,
  input  logic                    mem_af_afull_i,
  input  logic                    mem_df_afull_i,
  input  logic [beat_width_c-1:0] mem_data_i,
  input  logic                    mem_dvalid_i
);

  logic                     start;
  logic                     test_rst;
  logic [burst_width_c-1:0] burst_count;
  logic [addr_width_c-1:0]  rdblk_addr;
  logic                     phase_write;
  logic                     phase_turn;
  logic                     read_end;
  logic                     done;
  logic                     fault;
  logic                     afull_event;
  logic [burst_width_c-1:0] afull_addr;
  logic [FAULT_DEPTH*2*beat_width_c-1:0] fault_data;
  logic [FAULT_DEPTH*addr_width_c-1:0]   fault_addr;
  logic [RDBLK_DEPTH*2*beat_width_c-1:0] rdblk_data;
  logic [RDBLK_DEPTH*addr_width_c-1:0]   rdblk_addr_cap;

  memtest_regs #(
    .FAULT_DEPTH (FAULT_DEPTH),
    .RDBLK_DEPTH (RDBLK_DEPTH)
  ) u_regs (
    .clk              (clk),
    .module_rst       (module_rst),
    .phy_rdy_i        (phy_rdy_i),
    .bus_cyc_i        (bus_cyc_i),
    .bus_stb_i        (bus_stb_i),
    .bus_we_i         (bus_we_i),
    .bus_adr_i        (bus_adr_i),
    .bus_dat_i        (bus_dat_i),
    .bus_dat_o        (bus_dat_o),
    .bus_ack_o        (bus_ack_o),
    .start_o          (start),
    .test_rst_o       (test_rst),
    .burst_count_o    (burst_count),
    .rdblk_addr_o     (rdblk_addr),
    .status_i         ({afull_event, fault, done}),
    .afull_addr_i     (afull_addr),
    .fault_data_i     (fault_data),
    .fault_addr_i     (fault_addr),
    .rdblk_data_i     (rdblk_data),
    .rdblk_addr_cap_i (rdblk_addr_cap)
  );

  memtest_sequencer u_sequencer (
    .clk            (clk),
    .test_rst_i     (test_rst),
    .start_i        (start),
    .burst_count_i  (burst_count),
    .mem_af_afull_i (mem_af_afull_i),
    .mem_df_afull_i (mem_df_afull_i),
    .read_end_i     (read_end),
    .mem_rd_wr_n_o  (mem_rd_wr_n_o),
    .mem_addr_o     (mem_addr_o),
    .mem_data_o     (mem_data_o),
    .mem_af_we_o    (mem_af_we_o),
    .mem_df_we_o    (mem_df_we_o),
    .phase_write_o  (phase_write),
    .phase_turn_o   (phase_turn),
    .done_o         (done),
    .afull_event_o  (afull_event),
    .afull_addr_o   (afull_addr)
  );

  memtest_checker #(
    .FAULT_DEPTH (FAULT_DEPTH),
    .RDBLK_DEPTH (RDBLK_DEPTH)
  ) u_checker (
    .clk              (clk),
    .test_rst_i       (test_rst),
    .phase_write_i    (phase_write),
    .phase_turn_i     (phase_turn),
    .rdblk_addr_i     (rdblk_addr),
    .mem_data_i       (mem_data_i),
    .mem_dvalid_i     (mem_dvalid_i),
    .read_end_o       (read_end),
    .fault_o          (fault),
    .fault_data_o     (fault_data),
    .fault_addr_o     (fault_addr),
    .rdblk_data_o     (rdblk_data),
    .rdblk_addr_cap_o (rdblk_addr_cap)
  );

endmodule

/* sim/ddr_model.sv */
`timescale 1ns/1ps
// Behavioral DDR controller
module ddr_model import memtest_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    mode_i,
  input  logic                    inject_en_i,
  input  logic [addr_width_c-1:0] inject_addr_i,
  input  logic                    mem_rd_wr_n_i,
  input  logic [addr_width_c-1:0] mem_addr_i,
  input  logic [beat_width_c-1:0] mem_data_i,
  input  logic                    mem_af_we_i,
  input  logic                    mem_df_we_i,
  output logic                    mem_af_afull_o,
  output logic                    mem_df_afull_o,
  output logic [beat_width_c-1:0] rd_data_o,
  output logic                    rd_valid_o,
  output logic                    overflow_o
);

  localparam int latency_c = 6;

  logic [2*beat_width_c-1:0] mem [logic [addr_width_c-1:0]];  // Sparse storage
  logic [addr_width_c-1:0]   addr_fifo [$];
  logic [addr_width_c-1:0]   pipe_addr [$];
  int                        pipe_due [$];
  logic [beat_width_c-1:0]   wr_lo;
  logic [addr_width_c-1:0]   wr_addr;
  logic [2*beat_width_c-1:0] rd_burst;
  logic [31:0]               rng;
  int                        af_cnt_q;
  logic                      hold_q;
  logic                      wr_phase_q;
  logic                      df_afull_d_q;  // Data FIFO flag of the previous cycle
  logic                      second;
  logic                      busy;
  int                        cyc;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  assign mem_af_afull_o = (af_cnt_q >= 3);
  assign mem_df_afull_o = hold_q & wr_phase_q;  // Forced stretches only while writing

  always @(posedge clk) begin
    if (rst_i) begin
      addr_fifo.delete();
      pipe_addr.delete();
      pipe_due.delete();
      rng         = 32'h58ca_3b63;
      second      = 1'b0;
      busy        = 1'b0;
      cyc         = 0;
      af_cnt_q   <= 0;
      hold_q     <= 1'b0;
      wr_phase_q <= 1'b0;
      df_afull_d_q <= 1'b0;
      rd_valid_o <= 1'b0;
      rd_data_o  <= '0;
      overflow_o <= 1'b0;
    end else begin
      cyc++;
      // One read accepted every two cycles
      if (busy) begin
        busy = 1'b0;
      end else if (addr_fifo.size() > 0) begin
        pipe_addr.push_back(addr_fifo.pop_front());
        pipe_due.push_back(cyc + latency_c);
        busy = 1'b1;
      end
      rd_valid_o <= 1'b0;
      if (second) begin
        rd_data_o  <= rd_burst[2*beat_width_c-1:beat_width_c];
        rd_valid_o <= 1'b1;
        second = 1'b0;
      end else if (pipe_due.size() > 0 && pipe_due[0] <= cyc) begin
        rd_burst = mem.exists(pipe_addr[0]) ? mem[pipe_addr[0]] : '0;
        if (inject_en_i && pipe_addr[0] == inject_addr_i) begin
          rd_burst[0] = ~rd_burst[0];  // Lane 0 XOR 1
        end
        void'(pipe_addr.pop_front());
        void'(pipe_due.pop_front());
        rd_data_o  <= rd_burst[beat_width_c-1:0];
        rd_valid_o <= 1'b1;
        second = 1'b1;
      end
      if (mem_af_we_i && mem_rd_wr_n_i) begin
        addr_fifo.push_back(mem_addr_i);
        wr_phase_q <= 1'b0;
      end
      if (mem_df_we_i) begin
        if (mem_af_we_i) begin
          wr_addr = mem_addr_i;
          wr_lo   = mem_data_i;
          wr_phase_q <= 1'b1;
        end else begin
          mem[wr_addr] = {mem_data_i, wr_lo};
        end
      end
      if (addr_fifo.size() > 4) overflow_o <= 1'b1;
      // New burst started while the data FIFO was almost full
      if (mem_df_we_i && mem_af_we_i && df_afull_d_q) overflow_o <= 1'b1;
      df_afull_d_q <= mem_df_afull_o;
      af_cnt_q <= addr_fifo.size();
      if (mode_i) begin
        rng = next_random(rng);
        hold_q <= hold_q ? rng[0] : (rng[1:0] == 2'b00);
      end else begin
        hold_q <= 1'b0;
      end
    end
  end

endmodule

/* sim/memtest_tb.sv */
`timescale 1ns/1ps
// Memory tester testbench
module memtest_tb import memtest_pkg::*; ();

  localparam int depth_c           = 4;
  localparam int num_tests_c       = 5;
  localparam int fault_addr_base_c = fault_base_c + depth_c * halfwords_per_burst_c;
  localparam int rdblk_data_base_c = fault_addr_base_c + depth_c * 2;
  localparam int rdblk_addr_base_c = rdblk_data_base_c + depth_c * halfwords_per_burst_c;

  // Test table, inject -1 is none, action 1 ctrl reset, 2 PHY drop
  string name_tab   [num_tests_c] = '{"clean", "inject", "ctrl_reset", "backpressure", "phy_drop"};
  int    bursts_tab [num_tests_c] = '{8, 12, 6, 16, 10};
  int    rdblk_tab  [num_tests_c] = '{8, 16, 4, 40, 24};
  int    inject_tab [num_tests_c] = '{-1, 20, -1, -1, -1};
  int    mode_tab   [num_tests_c] = '{0, 0, 0, 1, 0};
  int    action_tab [num_tests_c] = '{0, 0, 1, 0, 2};

  logic        clk;
  logic        module_rst;
  logic        phy_rdy;
  logic        bus_cyc;
  logic        bus_stb;
  logic        bus_we;
  logic [15:0] bus_adr;
  logic [15:0] bus_wdat;
  logic [15:0] bus_rdat;
  logic        bus_ack;
  logic        mem_rd_wr_n;
  logic        mem_af_we;
  logic        mem_df_we;
  logic        af_afull;
  logic        df_afull;
  logic        rd_valid;
  logic        overflow;
  logic        mem_mode;
  logic        inject_en;
  logic [addr_width_c-1:0] mem_addr;
  logic [addr_width_c-1:0] inject_addr;
  logic [beat_width_c-1:0] wr_data;
  logic [beat_width_c-1:0] rd_data;
  int          errors;
  int          pass_cnt;
  int          fail_cnt;

  memtest_top #(.FAULT_DEPTH(depth_c), .RDBLK_DEPTH(depth_c)) i_dut (
    .clk (clk), .module_rst (module_rst), .phy_rdy_i (phy_rdy),
    .bus_cyc_i (bus_cyc), .bus_stb_i (bus_stb), .bus_we_i (bus_we), .bus_adr_i (bus_adr),
    .bus_dat_i (bus_wdat), .bus_dat_o (bus_rdat), .bus_ack_o (bus_ack),
    .mem_rd_wr_n_o (mem_rd_wr_n), .mem_addr_o (mem_addr), .mem_data_o (wr_data),
    .mem_af_we_o (mem_af_we), .mem_df_we_o (mem_df_we), .mem_af_afull_i (af_afull),
    .mem_df_afull_i (df_afull), .mem_data_i (rd_data), .mem_dvalid_i (rd_valid)
  );

  ddr_model u_mem (
    .clk (clk), .rst_i (module_rst), .mode_i (mem_mode), .inject_en_i (inject_en),
    .inject_addr_i (inject_addr), .mem_rd_wr_n_i (mem_rd_wr_n), .mem_addr_i (mem_addr),
    .mem_data_i (wr_data), .mem_af_we_i (mem_af_we), .mem_df_we_i (mem_df_we),
    .mem_af_afull_o (af_afull), .mem_df_afull_o (df_afull), .rd_data_o (rd_data),
    .rd_valid_o (rd_valid), .overflow_o (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Lane k of burst n is 4n+k, lane 0 flipped at the injected address
  function automatic logic [255:0] expected_burst(input int n, input int inj);
    logic [255:0] b;
    for (int k = 0; k < 4; k++) b[k*64 +: 64] = 64'(4 * n + k);
    if (inj == 4 * n) b[0] = ~b[0];
    return b;
  endfunction

  task automatic compare_value(input string what, input logic [255:0] exp_v,
                               input logic [255:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR %s expected %0h actual %0h", what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic bus_access(input logic we, input int adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    @(posedge clk);
    #1;
    bus_cyc  = 1'b1;
    bus_stb  = 1'b1;
    bus_we   = we;
    bus_adr  = 16'(adr);
    bus_wdat = wdat;
    do begin
      @(posedge clk);
      #1;
    end while (!bus_ack);
    rdat    = bus_rdat;
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic bus_write(input int adr, input logic [15:0] wdat);
    logic [15:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic read_words(input int base, input int count, output logic [255:0] val);
    logic [15:0] w;
    val = '0;
    for (int i = 0; i < count; i++) begin
      bus_access(1'b0, base + i, 16'h0000, w);
      val[i*16 +: 16] = w;
    end
  endtask

  initial begin : watchdog
    int limit;
    limit = 0;
    for (int i = 0; i < num_tests_c; i++) limit += 40 * bursts_tab[i] + 500;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, a test did not finish", limit);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    logic [255:0] val;
    int           n;
    int           inj;
    int           err_before;
    module_rst  = 1'b1;
    phy_rdy     = 1'b1;
    {bus_cyc, bus_stb, bus_we} = 3'b000;
    bus_adr     = '0;
    bus_wdat    = '0;
    mem_mode    = 1'b0;
    inject_en   = 1'b0;
    inject_addr = '0;
    errors      = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    repeat (2) @(posedge clk);
    #1 module_rst = 1'b0;
    for (int t = 0; t < num_tests_c; t++) begin
      err_before = errors;
      n   = bursts_tab[t];
      inj = inject_tab[t];
      if (action_tab[t] == 1) begin
        bus_write(ctrl_reg_c, 16'h0002);  // Rising edge of the reset bit
        read_words(status_reg_c, 1, val);
        compare_value($sformatf("%s status after reset", name_tab[t]), 0, val);
      end else if (action_tab[t] == 2) begin
        @(posedge clk);
        #1 phy_rdy = 1'b0;
        repeat (3) @(posedge clk);
        #1 phy_rdy = 1'b1;
        read_words(status_reg_c, 1, val);
        compare_value($sformatf("%s status after PHY drop", name_tab[t]), 0, val);
      end
      @(posedge clk);
      #1;
      mem_mode    = (mode_tab[t] != 0);
      inject_en   = (inj >= 0);
      inject_addr = addr_width_c'(inj);
      bus_write(size_lo_reg_c, 16'(n));
      bus_write(size_hi_reg_c, 16'(n >> 16));
      bus_write(rdblk_reg_c, 16'(rdblk_tab[t]));
      bus_write(ctrl_reg_c, 16'h0000);
      bus_write(ctrl_reg_c, 16'h0001);
      do begin
        read_words(status_reg_c, 1, val);
      end while (!val[0]);
      compare_value($sformatf("%s fault bit", name_tab[t]), 256'(inj >= 0), 256'(val[1]));
      if (mode_tab[t] != 0) begin
        compare_value($sformatf("%s afull event", name_tab[t]), 1, 256'(val[2]));
        read_words(afull_reg_c, 2, val);
        compare_value($sformatf("%s afull addr below N", name_tab[t]), 1,
                      256'(val < 256'(n)));
      end
      read_words(fault_base_c, halfwords_per_burst_c, val);
      compare_value($sformatf("%s fault slot0 data", name_tab[t]),
                    (inj >= 0) ? expected_burst(inj / 4, inj) : 256'(0), val);
      read_words(fault_addr_base_c, 2, val);
      compare_value($sformatf("%s fault slot0 addr", name_tab[t]),
                    (inj >= 0) ? 256'(inj) : 256'(0), val);
      read_words(fault_base_c + halfwords_per_burst_c, halfwords_per_burst_c, val);
      compare_value($sformatf("%s fault slot1 data", name_tab[t]), 0, val);
      read_words(fault_addr_base_c + 2, 2, val);
      compare_value($sformatf("%s fault slot1 addr", name_tab[t]), 0, val);
      for (int j = 0; j < depth_c; j++) begin
        read_words(rdblk_data_base_c + j * halfwords_per_burst_c, halfwords_per_burst_c, val);
        compare_value($sformatf("%s rdblk%0d data", name_tab[t], j),
                      expected_burst(rdblk_tab[t] / 4 + j, inj), val);
        read_words(rdblk_addr_base_c + 2 * j, 2, val);
        compare_value($sformatf("%s rdblk%0d addr", name_tab[t], j),
                      256'(rdblk_tab[t] + 4 * j), val);
      end
      compare_value($sformatf("%s FIFO overflow", name_tab[t]), 0, 256'(overflow));
      if (errors == err_before) begin
        $display("test %s: ok", name_tab[t]);
        pass_cnt++;
      end else begin
        $display("test %s: %0d mismatches", name_tab[t], errors - err_before);
        fail_cnt++;
      end
    end
    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sources.f */
src/memtest_pkg.sv
src/memtest_regs.sv
src/memtest_sequencer.sv
src/memtest_checker.sv
src/memtest_top.sv
sim/ddr_model.sv
sim/memtest_tb.sv
